/* memCtrl.f */
hw/memCtrlPkg.sv
hw/requestArbiter.sv
hw/byteSequencer.sv
hw/resultAssembler.sv
hw/memCtrl.sv
sim/memCtrl_checker.sv
sim/memCtrlTb.sv

/* Makefile */
TOP := memCtrlTb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f memCtrl.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f memCtrl.f
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

/* sim/memCtrlTb.sv */
`timescale 1ns/1ps
`default_nettype none

module memCtrlTb;
    import memCtrlPkg::*;

    localparam int DoneTimeout = 200;

    logic        clk, rst, rdy, ioBufferFull;
    logic        fetchReq, dataReq, dataStore;
    addrT        fetchAddr, dataAddr;
    byteCountT   dataLen;
    wordT        dataWrite;
    memByteT     ramQ;
    logic [15:0] lfsr;
    memByteT     ram [0:255];
    memByteT     shadow [0:255];
    wire          memWrite, fetchDone, dataDone;
    wire addrT    memAddr;
    wire memByteT memWriteData;
    wire wordT    fetchInst, dataRead;

    memCtrl memCtrl_i (
        .clk(clk), .rst(rst), .i_rdy(rdy), .i_ioBufferFull(ioBufferFull),
        .i_memData(ramQ), .o_memWrite(memWrite), .o_memAddr(memAddr),
        .o_memData(memWriteData), .i_fetchReq(fetchReq), .i_fetchAddr(fetchAddr),
        .o_fetchDone(fetchDone), .o_fetchInst(fetchInst), .i_dataReq(dataReq),
        .i_dataStore(dataStore), .i_dataLen(dataLen), .i_dataAddr(dataAddr),
        .i_dataWrite(dataWrite), .o_dataDone(dataDone), .o_dataRead(dataRead)
    );

    always #10 clk = ~clk;

    // byte RAM on the low address bits with a one-cycle read
    initial begin
        ramQ <= '0;
        for (int i = 0; i < 256; i++) begin
            ram[i] <= fillByte(i);
        end
        forever begin
            @(posedge clk);
            if (memWrite) begin
                ram[memAddr[7:0]] <= memWriteData;
            end
            ramQ <= ram[memAddr[7:0]];
        end
    end

    function automatic memByteT fillByte(input int a);
        return memByteT'((a * 37 + 11) ^ (a >> 3));
    endfunction

    // Fibonacci LFSR x^16 + x^14 + x^13 + x^11 + 1 stepped once per bit
    function automatic logic [31:0] randBits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    // little-endian word from the shadow RAM with zeros above len
    function automatic wordT expectedRead(input addrT addr, input int len);
        wordT w;
        w = '0;
        for (int k = 0; k < len; k++) begin
            w[k*ByteWidth +: ByteWidth] = shadow[8'(addr + addrT'(k))];
        end
        return w;
    endfunction

    task automatic failRun(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic checkEq(input logic [31:0] got, input logic [31:0] exp,
                           input string what);
        assert (got === exp) else begin
            failRun($sformatf("CHECK FAILED at %0t: %s is %h, expected %h",
                              $time, what, got, exp));
        end
    endtask

    task automatic driveStall(input bit stallOn);
        // each source stalls about one cycle in four
        rdy = !stallOn || (randBits(2) != 0);
        ioBufferFull = stallOn && (randBits(2) == 0);
    endtask

    // edges counted from the one that can accept the request
    task automatic waitDone(input bit dataSide, input bit stallOn, output int edges);
        logic gotDone;
        gotDone = 1'b0;
        edges = 0;
        while (!gotDone) begin
            @(posedge clk);
            #1;
            edges++;
            checkEq(32'(dataSide ? fetchDone : dataDone), 32'd0, "done of the other port");
            gotDone = dataSide ? dataDone : fetchDone;
            if (!gotDone && edges >= DoneTimeout) begin
                failRun("timeout while waiting for a done pulse");
            end
            driveStall(stallOn);
        end
    endtask

    // raises the chosen ports together and expects data done first
    task automatic runJobs(input bit doFetch, input bit doData, input bit store,
                           input int len, input addrT addr, input bit stallOn);
        int   edges;
        wordT expData;
        wordT expInst;
        @(posedge clk);
        #1;
        fetchReq = doFetch;
        fetchAddr = addrT'(randBits(10));
        dataReq = doData;
        dataStore = store;
        dataLen = byteCountT'(len);
        dataAddr = addr;
        dataWrite = randBits(32);
        expData = expectedRead(addr, len);
        expInst = expectedRead(fetchAddr, WordBytes);
        driveStall(stallOn);
        if (doData) begin
            waitDone(1'b1, stallOn, edges);
            if (store) begin
                for (int k = 0; k < len; k++) begin
                    shadow[8'(addr + addrT'(k))] = dataWrite[k*ByteWidth +: ByteWidth];
                end
            end else begin
                checkEq(dataRead, expData, "data read");
            end
            if (!stallOn && !doFetch) begin
                checkEq(edges, store ? len + 1 : len + 2, "data latency");
            end
            @(posedge clk);
            #1;
            dataReq = 1'b0;
        end
        if (doFetch) begin
            waitDone(1'b0, stallOn, edges);
            checkEq(fetchInst, expInst, "fetched instruction");
            if (!stallOn && !doData) begin
                checkEq(edges, WordBytes + 2, "fetch latency");
            end
            @(posedge clk);
            #1;
            fetchReq = 1'b0;
        end
    endtask

    initial begin
        addrT addr;
        bit   stallOn;
        int   len;
        lfsr = 16'd41;
        clk = 1'b0;
        rst = 1'b1;
        rdy = 1'b1;
        ioBufferFull = 1'b0;
        {fetchReq, dataReq, dataStore} = '0;
        {fetchAddr, dataAddr, dataWrite, dataLen} = '0;
        for (int i = 0; i < 256; i++) begin
            shadow[i] = fillByte(i);
        end
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        // first round without stalls keeps the latencies exact
        for (int round = 0; round < 2; round++) begin
            stallOn = (round == 1);
            for (int n = 0; n < 6; n++) begin
                addr = addrT'(randBits(10));
                len = 1 << (n % 3);
                runJobs(1'b1, 1'b0, 1'b0, 4, addr, stallOn);
                runJobs(1'b0, 1'b1, 1'b0, len, addr, stallOn);
                runJobs(1'b0, 1'b1, 1'b1, len, addr, stallOn);
                runJobs(1'b0, 1'b1, 1'b0, 4, addr, stallOn);
                runJobs(1'b1, 1'b1, 1'b0, len, addr, stallOn);
            end
        end
        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire

/* sim/memCtrl_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module memCtrlChecker (
    input wire clk,
    input wire rst,
    input wire i_rdy,
    input wire i_ioBufferFull,
    input wire i_memWrite,
    input wire i_fetchDone,
    input wire i_dataDone
);

    // done strobes last one cycle
    fetchDoneOnce: assert property (@(posedge clk) disable iff (rst)
        i_fetchDone |=> !i_fetchDone) else $error("fetch done held for two cycles");
    dataDoneOnce: assert property (@(posedge clk) disable iff (rst)
        i_dataDone |=> !i_dataDone) else $error("data done held for two cycles");

    // one owner finishes at a time
    singleDone: assert property (@(posedge clk) disable iff (rst)
        !(i_fetchDone && i_dataDone)) else $error("fetch and data done together");

    noStallWrite: assert property (@(posedge clk) disable iff (rst)
        (!i_rdy || i_ioBufferFull) |-> !i_memWrite) else $error("RAM write during a stall");

    // quiet on the cycle after any reset edge
    quietAfterReset: assert property (@(posedge clk)
        rst |=> !i_memWrite && !i_fetchDone && !i_dataDone)
        else $error("RAM write or done pulse right after reset");

endmodule

bind memCtrl memCtrlChecker checker_i (
    .clk            (clk),
    .rst            (rst),
    .i_rdy          (i_rdy),
    .i_ioBufferFull (i_ioBufferFull),
    .i_memWrite     (o_memWrite),
    .i_fetchDone    (o_fetchDone),
    .i_dataDone     (o_dataDone)
);

`default_nettype wire

/* hw/memCtrl.sv */
`timescale 1ns/1ps
`default_nettype none

module memCtrl (
    input  wire                        clk,
    input  wire                        rst,
    input  wire                        i_rdy,
    input  wire                        i_ioBufferFull,
    input  wire memCtrlPkg::memByteT   i_memData,
    output wire                        o_memWrite,
    output wire memCtrlPkg::addrT      o_memAddr,
    output wire memCtrlPkg::memByteT   o_memData,
    input  wire                        i_fetchReq,
    input  wire memCtrlPkg::addrT      i_fetchAddr,
    output wire                        o_fetchDone,
    output wire memCtrlPkg::wordT      o_fetchInst,
    input  wire                        i_dataReq,
    input  wire                        i_dataStore,
    input  wire memCtrlPkg::byteCountT i_dataLen,
    input  wire memCtrlPkg::addrT      i_dataAddr,
    input  wire memCtrlPkg::wordT      i_dataWrite,
    output wire                        o_dataDone,
    output wire memCtrlPkg::wordT      o_dataRead
);
    import memCtrlPkg::*;

    wire            start;
    wire            ownerData;
    wire addrT      jobAddr;
    wire byteCountT jobLen;
    wire            jobStore;
    wire wordT      jobWrite;
    wire            idle;
    wire            advance;
    wire            capture;
    wire byteCountT captureIndex;
    wire            finish;

    requestArbiter arbiter_i (
        .clk         (clk),
        .rst         (rst),
        .i_fetchReq  (i_fetchReq),
        .i_fetchAddr (i_fetchAddr),
        .i_dataReq   (i_dataReq),
        .i_dataStore (i_dataStore),
        .i_dataLen   (i_dataLen),
        .i_dataAddr  (i_dataAddr),
        .i_dataWrite (i_dataWrite),
        .i_idle      (idle),
        .i_advance   (advance),
        .o_start     (start),
        .o_ownerData (ownerData),
        .o_jobAddr   (jobAddr),
        .o_jobLen    (jobLen),
        .o_jobStore  (jobStore),
        .o_jobWrite  (jobWrite)
    );

    byteSequencer sequencer_i (
        .clk            (clk),
        .rst            (rst),
        .i_rdy          (i_rdy),
        .i_ioBufferFull (i_ioBufferFull),
        .i_start        (start),
        .i_jobAddr      (jobAddr),
        .i_jobLen       (jobLen),
        .i_jobStore     (jobStore),
        .i_jobWrite     (jobWrite),
        .o_idle         (idle),
        .o_advance      (advance),
        .o_memWrite     (o_memWrite),
        .o_memAddr      (o_memAddr),
        .o_memData      (o_memData),
        .o_capture      (capture),
        .o_captureIndex (captureIndex),
        .o_finish       (finish)
    );

    resultAssembler assembler_i (
        .clk            (clk),
        .rst            (rst),
        .i_advance      (advance),
        .i_capture      (capture),
        .i_captureIndex (captureIndex),
        .i_finish       (finish),
        .i_ownerData    (ownerData),
        .i_jobLen       (jobLen),
        .i_memData      (i_memData),
        .o_fetchDone    (o_fetchDone),
        .o_fetchInst    (o_fetchInst),
        .o_dataDone     (o_dataDone),
        .o_dataRead     (o_dataRead)
    );

endmodule

`default_nettype wire

/* hw/resultAssembler.sv */
`timescale 1ns/1ps
`default_nettype none

module resultAssembler (
    input  wire                        clk,
    input  wire                        rst,
    input  wire                        i_advance,
    input  wire                        i_capture,
    input  wire memCtrlPkg::byteCountT i_captureIndex,
    input  wire                        i_finish,
    input  wire                        i_ownerData,
    input  wire memCtrlPkg::byteCountT i_jobLen,
    input  wire memCtrlPkg::memByteT   i_memData,
    output logic                       o_fetchDone,
    output memCtrlPkg::wordT           o_fetchInst,
    output logic                       o_dataDone,
    output memCtrlPkg::wordT           o_dataRead
);
    import memCtrlPkg::*;

    wordT byteBuf;
    wordT merged;

    // buffer plus this cycle's byte, zero above the job length
    always_comb begin
        merged = '0;
        for (int k = 0; k < WordBytes; k++) begin
            if (byteCountT'(k) < i_jobLen) begin
                if (i_capture && (i_captureIndex == byteCountT'(k))) begin
                    merged[k*ByteWidth +: ByteWidth] = i_memData;
                end else begin
                    merged[k*ByteWidth +: ByteWidth] = byteBuf[k*ByteWidth +: ByteWidth];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            byteBuf     <= '0;
            o_fetchDone <= 1'b0;
            o_dataDone  <= 1'b0;
            o_fetchInst <= '0;
            o_dataRead  <= '0;
        end else begin
            // done drops after one cycle even under a stall
            o_fetchDone <= i_advance && i_finish && !i_ownerData;
            o_dataDone  <= i_advance && i_finish && i_ownerData;
            if (i_advance) begin
                if (i_finish) begin
                    // empty again for the next job
                    byteBuf <= '0;
                    if (i_ownerData) begin
                        o_dataRead <= merged;
                    end else begin
                        o_fetchInst <= merged;
                    end
                end else if (i_capture) begin
                    byteBuf <= merged;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* hw/byteSequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module byteSequencer (
    input  wire                        clk,
    input  wire                        rst,
    input  wire                        i_rdy,
    input  wire                        i_ioBufferFull,
    input  wire                        i_start,
    input  wire memCtrlPkg::addrT      i_jobAddr,
    input  wire memCtrlPkg::byteCountT i_jobLen,
    input  wire                        i_jobStore,
    input  wire memCtrlPkg::wordT      i_jobWrite,
    output logic                       o_idle,
    output logic                       o_advance,
    output logic                       o_memWrite,
    output memCtrlPkg::addrT           o_memAddr,
    output memCtrlPkg::memByteT        o_memData,
    output logic                       o_capture,
    output memCtrlPkg::byteCountT      o_captureIndex,
    output logic                       o_finish
);
    import memCtrlPkg::*;

    seqStateT  state;
    byteCountT idx;
    byteCountT capIdx;
    logic      capPend;
    logic      issuing;
    logic      lastByte;
    addrT      issueAddr;
    addrT      addrHeld;

    assign o_advance = i_rdy && !i_ioBufferFull;

    // still idle while start waits out a stall
    assign o_idle = (state == seqIdle) && !i_start;

    // byte 0 goes out in the start cycle itself
    assign issuing = (state == seqIssue) || ((state == seqIdle) && i_start);
    assign lastByte = idx == i_jobLen - byteCountT'(1);
    assign issueAddr = i_jobAddr + addrT'(idx);

    // during a stall the RAM sees the previous address, so its byte repeats
    assign o_memAddr = o_advance ? issueAddr : addrHeld;
    assign o_memWrite = issuing && i_jobStore && o_advance;
    assign o_memData = memByteT'(i_jobWrite >> (ByteWidth * idx));

    assign o_capture = capPend;
    assign o_captureIndex = capIdx;

    // stores end with their last write, loads one cycle later
    assign o_finish = (state == seqLast) || (issuing && lastByte && i_jobStore);

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= seqIdle;
            idx     <= '0;
            capPend <= 1'b0;
        end else if (o_advance) begin
            capPend <= issuing && !i_jobStore;
            if (issuing) begin
                if (lastByte) begin
                    state <= i_jobStore ? seqIdle : seqLast;
                    idx   <= '0;
                end else begin
                    state <= seqIssue;
                    idx   <= idx + byteCountT'(1);
                end
            end else begin
                state <= seqIdle;
            end
        end
    end

    // read byte returns one cycle after its address
    always_ff @(posedge clk) begin
        if (o_advance) begin
            addrHeld <= issueAddr;
            capIdx   <= idx;
        end
    end

endmodule

`default_nettype wire

/* hw/requestArbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module requestArbiter (
    input  wire                        clk,
    input  wire                        rst,
    input  wire                        i_fetchReq,
    input  wire memCtrlPkg::addrT      i_fetchAddr,
    input  wire                        i_dataReq,
    input  wire                        i_dataStore,
    input  wire memCtrlPkg::byteCountT i_dataLen,
    input  wire memCtrlPkg::addrT      i_dataAddr,
    input  wire memCtrlPkg::wordT      i_dataWrite,
    input  wire                        i_idle,
    input  wire                        i_advance,
    output logic                       o_start,
    output logic                       o_ownerData,
    output memCtrlPkg::addrT           o_jobAddr,
    output memCtrlPkg::byteCountT      o_jobLen,
    output logic                       o_jobStore,
    output memCtrlPkg::wordT           o_jobWrite
);
    import memCtrlPkg::*;

    logic busyLast;
    logic doneCycle;
    logic takeData;
    logic takeFetch;

    // first idle cycle after a job is its done cycle
    assign doneCycle = busyLast && i_idle;

    // the finished owner still holds its old request during done
    assign takeData = i_idle && i_advance && i_dataReq
                      && !(doneCycle && o_ownerData);
    assign takeFetch = i_idle && i_advance && i_fetchReq && !takeData
                       && !(doneCycle && !o_ownerData);

    always_ff @(posedge clk) begin
        if (rst) begin
            busyLast    <= 1'b0;
            o_start     <= 1'b0;
            o_ownerData <= 1'b0;
        end else begin
            busyLast <= !i_idle;
            // start stays up through a stall until the sequencer takes it
            if (i_advance) begin
                o_start <= takeData || takeFetch;
            end
            if (takeData) begin
                o_ownerData <= 1'b1;
            end else if (takeFetch) begin
                o_ownerData <= 1'b0;
            end
        end
    end

    // job fields stay put until the next accept
    always_ff @(posedge clk) begin
        if (takeData) begin
            o_jobAddr  <= i_dataAddr;
            o_jobLen   <= i_dataLen;
            o_jobStore <= i_dataStore;
            o_jobWrite <= i_dataWrite;
        end else if (takeFetch) begin
            o_jobAddr  <= i_fetchAddr;
            o_jobLen   <= byteCountT'(WordBytes);
            o_jobStore <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* hw/memCtrlPkg.sv */
`default_nettype none

package memCtrlPkg;

    // bus widths
    localparam int AddrWidth = 32;
    localparam int WordWidth = 32;
    localparam int ByteWidth = 8;

    // a fetch always moves a full word
    localparam int WordBytes = WordWidth / ByteWidth;

    typedef logic [AddrWidth-1:0] addrT;
    typedef logic [WordWidth-1:0] wordT;
    typedef logic [ByteWidth-1:0] memByteT;

    // holds 0 to WordBytes inclusive
    typedef logic [$clog2(WordBytes+1)-1:0] byteCountT;

    // seqIssue walks the bytes, seqLast waits for the final read byte
    typedef enum logic [1:0] {
        seqIdle,
        seqIssue,
        seqLast
    } seqStateT;

endpackage

`default_nettype wire
